//--- common/io_pkg.sv
/*
 * IO peripheral package
 * bus widths, register word addresses and timer control bit positions
 * shared by the timer, GPIO and software-interrupt blocks
 */

package io_pkg;

	// word address, byte address bits 15:2
	typedef logic [13:0] io_addr_t;
	typedef logic [31:0] io_data_t;

	// free-run counter and compare width
	typedef logic [39:0] frc_val_t;
	typedef logic [7:0]  gpio_t;

	// upper part of the 40-bit timer value
	localparam int FRC_HI_W = 8;

	// timer registers
	localparam io_addr_t ADR_FRC_VALLO = 14'h3E00;
	localparam io_addr_t ADR_FRC_VALHI = 14'h3E01;
	localparam io_addr_t ADR_FRC_CMPLO = 14'h3E02;
	localparam io_addr_t ADR_FRC_CMPHI = 14'h3E03;
	localparam io_addr_t ADR_FRC_CNTRL = 14'h3E04;

	// gpio and software interrupt
	localparam io_addr_t ADR_GPIO_OUT  = 14'h3E10;
	localparam io_addr_t ADR_GPIO_IN   = 14'h3E11;
	localparam io_addr_t ADR_SWINT     = 14'h3E20;

	// timer control word bits
	// run level, written and read back
	localparam int CTL_RUN = 0;
	// write 1 zeroes the counter
	localparam int CTL_CLR = 1;
	// write 0 clears the flag, reads as flag state
	localparam int CTL_IRQ = 2;

endpackage

//--- src/io_swint.sv
/*
 * Software-interrupt register
 * single machine software-interrupt pending bit, first stage of the
 * read chain
 */

`timescale 1ns/100ps

module io_swint import io_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     io_we,
	input  io_addr_t io_wadr,
	input  io_data_t io_wdata,
	input  io_addr_t io_radr,
	input  logic     io_radr_en,
	input  io_data_t rdata_in,
	output io_data_t rdata,
	output logic     sw_irq
);

	logic we_swint;
	logic re_swint;

	assign we_swint = io_we & (io_wadr == ADR_SWINT);

	// pending bit drives the interrupt line directly
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_irq <= 1'b0;
		end else if (we_swint) begin
			sw_irq <= io_wdata[0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			re_swint <= 1'b0;
		end else begin
			re_swint <= io_radr_en & (io_radr == ADR_SWINT);
		end
	end

	assign rdata = re_swint ? io_data_t'(sw_irq) : rdata_in;

endmodule

//--- src/io_gpio.sv
/*
 * GPIO port
 * eight output bits written from the bus, eight input pins brought in
 * through a two-flop synchronizer, both readable on the read chain
 */

`timescale 1ns/100ps

module io_gpio import io_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     io_we,
	input  io_addr_t io_wadr,
	input  io_data_t io_wdata,
	input  io_addr_t io_radr,
	input  logic     io_radr_en,
	input  io_data_t rdata_in,
	input  gpio_t    gpio_in,
	output io_data_t rdata,
	output gpio_t    gpio_out
);

	logic  we_out;
	gpio_t in_meta;
	gpio_t in_sync;
	logic  re_out;
	logic  re_in;

	assign we_out = io_we & (io_wadr == ADR_GPIO_OUT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gpio_out <= '0;
		end else if (we_out) begin
			gpio_out <= io_wdata[$bits(gpio_t)-1:0];
		end
	end

	// pins are asynchronous to clk
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_meta <= '0;
			in_sync <= '0;
		end else begin
			in_meta <= gpio_in;
			in_sync <= in_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			re_out <= 1'b0;
			re_in  <= 1'b0;
		end else begin
			re_out <= io_radr_en & (io_radr == ADR_GPIO_OUT);
			re_in  <= io_radr_en & (io_radr == ADR_GPIO_IN);
		end
	end

	// own value or pass the upstream word on
	always_comb begin
		if (re_out) begin
			rdata = io_data_t'(gpio_out);
		end else if (re_in) begin
			rdata = io_data_t'(in_sync);
		end else begin
			rdata = rdata_in;
		end
	end

endmodule

//--- frc/io_frc.sv
/*
 * Free-run counter timer
 * 40-bit counter with 40-bit compare, run and clear control and a
 * sticky compare interrupt gated by mtie; one stage of the read chain
 */

`timescale 1ns/100ps

module io_frc import io_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     io_we,
	input  io_addr_t io_wadr,
	input  io_data_t io_wdata,
	input  io_addr_t io_radr,
	input  logic     io_radr_en,
	input  io_data_t rdata_in,
	input  logic     csr_mtie,
	output io_data_t rdata,
	output logic     timer_irq
);

	localparam int LO_W = $bits(io_data_t);

	logic     we_vallo;
	logic     we_valhi;
	logic     we_cmplo;
	logic     we_cmphi;
	logic     we_cntrl;
	logic     cntr_clr;
	logic     run;
	frc_val_t cntr_val;
	frc_val_t cmp_val;
	logic [4:0] re_sel;
	io_data_t ctl_word;

	// write decode
	assign we_vallo = io_we & (io_wadr == ADR_FRC_VALLO);
	assign we_valhi = io_we & (io_wadr == ADR_FRC_VALHI);
	assign we_cmplo = io_we & (io_wadr == ADR_FRC_CMPLO);
	assign we_cmphi = io_we & (io_wadr == ADR_FRC_CMPHI);
	assign we_cntrl = io_we & (io_wadr == ADR_FRC_CNTRL);

	assign cntr_clr = we_cntrl & io_wdata[CTL_CLR];

	// clear beats loads, loads beat counting
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cntr_val <= '0;
		end else if (cntr_clr) begin
			cntr_val <= '0;
		end else if (we_vallo) begin
			cntr_val <= {cntr_val[LO_W +: FRC_HI_W], io_wdata};
		end else if (we_valhi) begin
			cntr_val <= {io_wdata[FRC_HI_W-1:0], cntr_val[LO_W-1:0]};
		end else if (run) begin
			cntr_val <= cntr_val + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmp_val <= '0;
		end else if (we_cmplo) begin
			cmp_val <= {cmp_val[LO_W +: FRC_HI_W], io_wdata};
		end else if (we_cmphi) begin
			cmp_val <= {io_wdata[FRC_HI_W-1:0], cmp_val[LO_W-1:0]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= 1'b0;
		end else if (we_cntrl) begin
			run <= io_wdata[CTL_RUN];
		end
	end

	// sticky flag, a clearing write wins over a new match
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else if (we_cntrl && !io_wdata[CTL_IRQ]) begin
			timer_irq <= 1'b0;
		end else if ((cntr_val >= cmp_val) && run && csr_mtie) begin
			timer_irq <= 1'b1;
		end
	end

	// one-hot read select, used one cycle after the request
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			re_sel <= '0;
		end else begin
			re_sel[0] <= io_radr_en & (io_radr == ADR_FRC_VALLO);
			re_sel[1] <= io_radr_en & (io_radr == ADR_FRC_VALHI);
			re_sel[2] <= io_radr_en & (io_radr == ADR_FRC_CMPLO);
			re_sel[3] <= io_radr_en & (io_radr == ADR_FRC_CMPHI);
			re_sel[4] <= io_radr_en & (io_radr == ADR_FRC_CNTRL);
		end
	end

	always_comb begin
		ctl_word = '0;
		ctl_word[CTL_RUN] = run;
		ctl_word[CTL_IRQ] = timer_irq;
	end

	// high words come back zero-extended
	always_comb begin
		if (re_sel[0]) begin
			rdata = cntr_val[LO_W-1:0];
		end else if (re_sel[1]) begin
			rdata = io_data_t'(cntr_val[LO_W +: FRC_HI_W]);
		end else if (re_sel[2]) begin
			rdata = cmp_val[LO_W-1:0];
		end else if (re_sel[3]) begin
			rdata = io_data_t'(cmp_val[LO_W +: FRC_HI_W]);
		end else if (re_sel[4]) begin
			rdata = ctl_word;
		end else begin
			rdata = rdata_in;
		end
	end

endmodule

//--- src/io_periph_top.sv
/*
 * IO peripheral block
 * software interrupt, GPIO and free-run timer on a shared write bus,
 * reads passed along a chain swint -> gpio -> frc
 */

`timescale 1ns/100ps

module io_periph_top import io_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     io_we,
	input  io_addr_t io_wadr,
	input  io_data_t io_wdata,
	input  io_addr_t io_radr,
	input  logic     io_radr_en,
	input  io_data_t rdata_in,
	input  logic     csr_mtie,
	input  gpio_t    gpio_in,
	output io_data_t rdata,
	output logic     timer_irq,
	output logic     sw_irq,
	output gpio_t    gpio_out
);

	// chain links between stages
	io_data_t rdata_swint;
	io_data_t rdata_gpio;

	io_swint u_swint (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.rdata_in   (rdata_in),
		.rdata      (rdata_swint),
		.sw_irq     (sw_irq)
	);

	io_gpio u_gpio (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.rdata_in   (rdata_swint),
		.gpio_in    (gpio_in),
		.rdata      (rdata_gpio),
		.gpio_out   (gpio_out)
	);

	// last stage drives the block output
	io_frc u_frc (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.rdata_in   (rdata_gpio),
		.csr_mtie   (csr_mtie),
		.rdata      (rdata),
		.timer_irq  (timer_irq)
	);

endmodule

//--- dv/tb_clk_gen.sv
/*
 * Testbench clock and reset
 * 4 ns clock, active-low reset held for the first 10 cycles
 */

`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	localparam int HALF_PERIOD = 2;
	localparam int RST_CYCLES  = 10;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- dv/io_periph_chk.sv
/*
 * Bus and interrupt checker for the IO peripheral block
 * concurrent assertions bound into io_periph_top
 */

`timescale 1ns/100ps

module io_periph_chk import io_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     io_we,
	input io_addr_t io_wadr,
	input io_data_t io_wdata,
	input io_addr_t io_radr,
	input logic     io_radr_en,
	input io_data_t rdata_in,
	input io_data_t rdata,
	input logic     timer_irq,
	input logic     sw_irq
);

	// count of failed assertions
	int fail_cnt = 0;

	a_strobes_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({io_we, io_radr_en}))
		else begin
			$error("write or read strobe is unknown after reset");
			fail_cnt++;
		end

	a_write_known: assert property (@(posedge clk) disable iff (!rst_n)
		io_we |-> !$isunknown({io_wadr, io_wdata}))
		else begin
			$error("write address or data is unknown during a write");
			fail_cnt++;
		end

	a_read_known: assert property (@(posedge clk) disable iff (!rst_n)
		io_radr_en |-> !$isunknown(io_radr))
		else begin
			$error("read address is unknown during a read");
			fail_cnt++;
		end

	// with no read selected the chain passes the outside word
	a_idle_pass: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(io_radr_en) |-> (rdata == rdata_in))
		else begin
			$error("rdata differs from rdata_in without a read");
			fail_cnt++;
		end

	a_irq_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(timer_irq) |-> $past(io_we && (io_wadr == ADR_FRC_CNTRL)))
		else begin
			$error("timer_irq fell without a control write");
			fail_cnt++;
		end

	a_swint_write: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(sw_irq) |-> $past(io_we && (io_wadr == ADR_SWINT)))
		else begin
			$error("sw_irq changed without a write to the register");
			fail_cnt++;
		end

endmodule

bind io_periph_top io_periph_chk u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.io_we      (io_we),
	.io_wadr    (io_wadr),
	.io_wdata   (io_wdata),
	.io_radr    (io_radr),
	.io_radr_en (io_radr_en),
	.rdata_in   (rdata_in),
	.rdata      (rdata),
	.timer_irq  (timer_irq),
	.sw_irq     (sw_irq)
);

//--- dv/tb_io_periph.sv
/*
 * Testbench for the IO peripheral block
 * replays bus operations from a pattern file and checks read data,
 * interrupt levels and GPIO pins against the expected values in it
 */

`timescale 1ns/100ps

module tb_io_periph import io_pkg::*; ();

	localparam int       MAX_CYCLES = 400;
	localparam io_data_t MARKER     = 32'hdead_beef;

	logic     clk;
	logic     rst_n;
	logic     io_we;
	io_addr_t io_wadr;
	io_data_t io_wdata;
	io_addr_t io_radr;
	logic     io_radr_en;
	io_data_t rdata_in;
	logic     csr_mtie;
	gpio_t    gpio_in;
	io_data_t rdata;
	logic     timer_irq;
	logic     sw_irq;
	gpio_t    gpio_out;
	int       cycle_cnt;

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.rst_n (rst_n)
	);

	io_periph_top dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.io_we      (io_we),
		.io_wadr    (io_wadr),
		.io_wdata   (io_wdata),
		.io_radr    (io_radr),
		.io_radr_en (io_radr_en),
		.rdata_in   (rdata_in),
		.csr_mtie   (csr_mtie),
		.gpio_in    (gpio_in),
		.rdata      (rdata),
		.timer_irq  (timer_irq),
		.sw_irq     (sw_irq),
		.gpio_out   (gpio_out)
	);

	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string sig, input io_data_t expected,
		input io_data_t actual);
		$display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
			$time, sig, expected, actual);
		stop_on_failure();
	endtask

	task automatic check_value(input string sig, input io_data_t expected,
		input io_data_t actual);
		assert (actual === expected)
		else report_mismatch(sig, expected, actual);
	endtask

	task automatic check_operands(input int got, input int want);
		if (got != want) begin
			$display("pattern file line has %0d operands where %0d are needed", got, want);
			stop_on_failure();
		end
	endtask

	// every operation starts on a rising edge with the strobes dropped
	task automatic next_cycle();
		@(posedge clk);
		io_we      <= 1'b0;
		io_radr_en <= 1'b0;
	endtask

	task automatic bus_write(input io_addr_t adr, input io_data_t data);
		next_cycle();
		io_we    <= 1'b1;
		io_wadr  <= adr;
		io_wdata <= data;
	endtask

	// data shows up in the cycle after the request
	task automatic bus_read_check(input io_addr_t adr, input io_data_t expected);
		next_cycle();
		io_radr_en <= 1'b1;
		io_radr    <= adr;
		next_cycle();
		@(negedge clk);
		check_value("rdata", expected, rdata);
	endtask

	task automatic replay_patterns(input int fd);
		int               op;
		int               n;
		io_data_t         arg_a;
		io_data_t         arg_b;
		logic [8*256-1:0] skip_buf;

		op = $fgetc(fd);
		while (op != -1) begin
			case (op)
				"#": n = $fgets(skip_buf, fd);
				// blanks and line ends between operations
				32, 9, 10, 13: n = 0;
				"W": begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					check_operands(n, 2);
					bus_write(io_addr_t'(arg_a), arg_b);
				end
				"R": begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					check_operands(n, 2);
					bus_read_check(io_addr_t'(arg_a), arg_b);
				end
				"I": begin
					n = $fscanf(fd, "%d", arg_a);
					check_operands(n, 1);
					repeat (arg_a) next_cycle();
				end
				"M": begin
					n = $fscanf(fd, "%h", arg_a);
					check_operands(n, 1);
					next_cycle();
					csr_mtie <= arg_a[0];
				end
				"G": begin
					n = $fscanf(fd, "%h", arg_a);
					check_operands(n, 1);
					next_cycle();
					gpio_in <= gpio_t'(arg_a);
				end
				"Q": begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					check_operands(n, 2);
					next_cycle();
					@(negedge clk);
					check_value("timer_irq", arg_a, io_data_t'(timer_irq));
					check_value("sw_irq", arg_b, io_data_t'(sw_irq));
				end
				"P": begin
					n = $fscanf(fd, "%h", arg_a);
					check_operands(n, 1);
					next_cycle();
					@(negedge clk);
					check_value("gpio_out", arg_a, io_data_t'(gpio_out));
				end
				default: begin
					$display("pattern file holds an unknown operation code %0d", op);
					stop_on_failure();
				end
			endcase
			op = $fgetc(fd);
		end
	endtask

	// run limit of about four times the pattern length
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout, the pattern replay did not finish within %0d cycles",
				MAX_CYCLES);
			stop_on_failure();
		end
	end

	// bound assertions on the bus and interrupts
	always @(negedge clk) begin
		if (dut.u_chk.fail_cnt != 0) begin
			$display("a bound assertion on the bus or the interrupts failed");
			stop_on_failure();
		end
	end

	initial begin
		int fd;

		cycle_cnt  = 0;
		io_we      = 1'b0;
		io_wadr    = '0;
		io_wdata   = '0;
		io_radr    = '0;
		io_radr_en = 1'b0;
		rdata_in   = MARKER;
		csr_mtie   = 1'b0;
		gpio_in    = '0;
		fd = $fopen("dv/io_periph_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file dv/io_periph_patterns.txt");
			stop_on_failure();
		end else begin
			wait (rst_n === 1'b1);
			next_cycle();
			replay_patterns(fd);
			$fclose(fd);
			next_cycle();
			@(negedge clk);
			if (dut.u_chk.fail_cnt != 0) begin
				$display("a bound assertion failed near the end of the replay");
				stop_on_failure();
			end else begin
				$display("TEST OK");
				$finish;
			end
		end
	end

endmodule

//--- dv/io_periph_patterns.txt
# op code then operands, all hex except the cycle count of I
# W adr data | R adr expect | I cycles | M mtie | G pins | Q timer_irq sw_irq | P gpio_out
# reset state
Q 0 0
P 00
R 3e04 00000000
# counter load and read-back with run 0
W 3e00 12345678
W 3e01 ffffffa5
R 3e00 12345678
R 3e01 000000a5
R 3e30 deadbeef
# count from the loaded value, six edges up to the read
W 3e04 00000001
I 5
R 3e00 1234567e
# clear and restart
W 3e04 00000003
I 3
R 3e00 00000004
R 3e01 00000000
# carry from bit 31 into the high word
W 3e00 fffffffe
I 2
R 3e01 00000001
R 3e00 00000003
# stop, counter frozen at 01_00000005
W 3e04 00000000
R 3e04 00000000
R 3e00 00000005
# compare at 01_00000010, counter runs past it with mtie 0
W 3e02 00000010
W 3e03 00000001
W 3e04 00000001
I 15
Q 0 0
M 1
Q 1 0
R 3e04 00000005
R 3e00 0000001a
# drop mtie first so the flag stays cleared
M 0
W 3e04 00000001
Q 0 0
R 3e04 00000001
# software interrupt
W 3e20 00000001
Q 0 1
R 3e20 00000001
W 3e20 00000000
Q 0 0
R 3e20 00000000
# gpio out and synchronized in
W 3e10 000000a5
P a5
G 3c
I 2
R 3e11 0000003c
R 3e10 000000a5
# read chain, every stage answers for itself
W 3e20 00000001
R 3e03 00000001
R 3e11 0000003c
R 3e20 00000001
R 3e02 00000010
R 3e10 000000a5
R 3e21 deadbeef
Q 0 1
P a5

//--- list.f
common/io_pkg.sv
src/io_swint.sv
src/io_gpio.sv
frc/io_frc.sv
src/io_periph_top.sv
dv/tb_clk_gen.sv
dv/io_periph_chk.sv
dv/tb_io_periph.sv

//--- Bender.yml
package:
  name: io_periph

sources:
  - common/io_pkg.sv
  - src/io_swint.sv
  - src/io_gpio.sv
  - frc/io_frc.sv
  - src/io_periph_top.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/io_periph_chk.sv
      - dv/tb_io_periph.sv
